// File: filelist.f
logic/i2c_host_pkg.sv
logic/i2c_proto_pkg.sv
logic/i2c_seq_ctrl.sv
logic/i2c_bit_timer.sv
logic/i2c_shift_unit.sv
logic/i2c_byte_buf.sv
logic/i2c_master_top.sv
verif/i2c_master_assert.sv
verif/i2c_slave_model.sv
verif/i2c_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module i2c_tb -f filelist.f --Mdir obj_dir -o sim_i2c
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_i2c +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1

// File: verif/i2c_tb.sv
module i2c_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_BITS = (11 + 9 * 5) + (11 + 9 * 4) + (11 + 9 * 2)
                             + (11 + 9 * 6) + (11 + 9 * 1);
    localparam int WATCHDOG_NS = TEST_BITS * 4 * 40 + 2000;

    logic                   I2C_CLK;
    logic                   RST;
    logic                   cmd_valid;
    logic                   cmd_ready;
    i2c_host_pkg::i2c_cmd_t cmd;
    logic                   rsp_valid;
    logic                   rsp_ready;
    i2c_host_pkg::i2c_rsp_t rsp;
    i2c_host_pkg::i2c_rsp_t rsp_got;
    logic                   buf_wr_en;
    logic [3:0]             buf_wr_addr;
    logic [7:0]             buf_wr_data;
    logic [3:0]             buf_rd_addr;
    logic [7:0]             buf_rd_data;
    logic                   dut_sda_oe;
    logic                   dut_scl_oe;
    logic                   slv_sda_oe;
    logic                   sda_line;
    logic                   scl_line;
    logic [7:0]             nack_after;
    logic [7:0]             wr_data [6];
    logic [7:0]             rd_byte;
    int                     errors;
    int                     test_errs;
    int                     tests_pass;
    int                     tests_fail;
    int                     scl_rises;

    // open-drain bus: a line is low whenever either side pulls it.
    assign sda_line = ~(dut_sda_oe | slv_sda_oe);
    assign scl_line = ~dut_scl_oe;

    i2c_master_top #(.BUF_BYTES(16)) i_dut (
        .I2C_CLK(I2C_CLK), .RST(RST), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd(cmd), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .buf_wr_en(buf_wr_en), .buf_wr_addr(buf_wr_addr), .buf_wr_data(buf_wr_data),
        .buf_rd_addr(buf_rd_addr), .buf_rd_data(buf_rd_data),
        .sda_in(sda_line), .scl_in(scl_line), .sda_oe(dut_sda_oe), .scl_oe(dut_scl_oe)
    );

    i2c_slave_model #(.DEV_ADDR(7'h50)) i_slave (
        .scl(scl_line), .sda(sda_line), .nack_after(nack_after), .sda_oe(slv_sda_oe)
    );

    always #20 I2C_CLK = ~I2C_CLK;

    // every rising SCL edge marks one clocked bit on the bus.
    always @(posedge scl_line) begin
        scl_rises++;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all transfers finished");
        $display("Test FAILED");
        $finish;
    end

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("FAILED %0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_errs) begin
            tests_pass++;
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_fail++;
            $display("test %0d %s: failed", num, name);
        end
        test_errs = errors;
    endtask

    task automatic load_buffer(input int count);
        for (int k = 0; k < count; k++) begin
            buf_wr_en   = 1'b1;
            buf_wr_addr = k[3:0];
            buf_wr_data = wr_data[k];
            @(posedge I2C_CLK);
            #5;
        end
        buf_wr_en = 1'b0;
    endtask

    task automatic read_buffer(input int addr);
        buf_rd_addr = addr[3:0];
        @(posedge I2C_CLK);
        #1;
        rd_byte = buf_rd_data;
        #4;
    endtask

    // issues one command, then waits for rsp_valid and captures rsp.
    task automatic run_transfer(input i2c_host_pkg::i2c_op_e op, input logic [6:0] addr,
                                input logic [7:0] len);
        cmd_valid = 1'b1;
        cmd       = '{op: op, dev_addr: addr, length: len};
        // cmd_ready only moves on a clock edge, so its value here holds at the next edge.
        while (!cmd_ready) begin
            @(posedge I2C_CLK);
            #5;
        end
        @(posedge I2C_CLK);
        #5;
        cmd_valid = 1'b0;
        do begin
            @(posedge I2C_CLK);
            #1;
        end while (!rsp_valid);
        rsp_got = rsp;
        #4;
    endtask

    task automatic accept_response();
        rsp_ready = 1'b1;
        @(posedge I2C_CLK);
        #5;
        rsp_ready = 1'b0;
    endtask

    initial begin
        I2C_CLK     = 1'b0;
        RST         = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_ready   = 1'b0;
        buf_wr_en   = 1'b0;
        buf_wr_addr = '0;
        buf_wr_data = '0;
        buf_rd_addr = '0;
        nack_after  = 8'hFF;
        errors      = 0;
        test_errs   = 0;
        tests_pass  = 0;
        tests_fail  = 0;
        scl_rises   = 0;
        void'($urandom(32'h99b6f71b));
        for (int k = 0; k < 6; k++)
            wr_data[k] = 8'($urandom);
        repeat (3) @(posedge I2C_CLK);
        #5;
        RST = 1'b0;
        @(posedge I2C_CLK);
        #1;
        check_eq("sda_oe", int'(dut_sda_oe), 0);
        check_eq("scl_oe", int'(dut_scl_oe), 0);
        check_eq("rsp_valid", int'(rsp_valid), 0);
        check_eq("cmd_ready", int'(cmd_ready), 1);
        #4;
        end_test(1, "reset state");

        load_buffer(5);
        run_transfer(i2c_host_pkg::OP_WRITE, 7'h50, 8'd5);
        check_eq("rsp.nack", int'(rsp_got.nack), 0);
        check_eq("rsp.bytes_done", int'(rsp_got.bytes_done), 5);
        accept_response();
        check_eq("slave wr_cnt", int'(i_slave.wr_cnt), 5);
        for (int k = 0; k < 5; k++) begin
            read_buffer(k);
            check_eq("slave wr_mem", int'(i_slave.wr_mem[k]), int'(rd_byte));
            check_eq("buf_rd_data", int'(rd_byte), int'(wr_data[k]));
        end
        end_test(2, "write 5 bytes");

        run_transfer(i2c_host_pkg::OP_READ, 7'h50, 8'd4);
        check_eq("rsp.nack", int'(rsp_got.nack), 0);
        check_eq("rsp.bytes_done", int'(rsp_got.bytes_done), 4);
        accept_response();
        check_eq("slave nack_cnt", i_slave.nack_cnt, 1);
        check_eq("slave nack_idx", i_slave.nack_idx, 3);
        for (int k = 0; k < 4; k++) begin
            read_buffer(k);
            check_eq("buf_rd_data", int'(rd_byte), k ^ 8'hA5);
        end
        end_test(3, "read 4 bytes");

        scl_rises = 0;
        run_transfer(i2c_host_pkg::OP_WRITE, 7'h3C, 8'd2);
        check_eq("rsp.nack", int'(rsp_got.nack), 1);
        check_eq("rsp.bytes_done", int'(rsp_got.bytes_done), 0);
        // eight address clocks, the acknowledge clock and the STOP clock, with no data byte.
        check_eq("scl rising edges", scl_rises, 10);
        accept_response();
        end_test(4, "address nack");

        load_buffer(6);
        nack_after = 8'd2;
        run_transfer(i2c_host_pkg::OP_WRITE, 7'h50, 8'd6);
        check_eq("rsp.nack", int'(rsp_got.nack), 1);
        check_eq("rsp.bytes_done", int'(rsp_got.bytes_done), 2);
        check_eq("slave stop_seen", int'(i_slave.stop_seen), 1);
        accept_response();
        nack_after = 8'hFF;
        end_test(5, "data nack");

        run_transfer(i2c_host_pkg::OP_WRITE, 7'h50, 8'd1);
        repeat (20) begin
            @(posedge I2C_CLK);
            #1;
            check_eq("rsp_valid", int'(rsp_valid), 1);
            check_eq("rsp", int'(rsp), int'(rsp_got));
            check_eq("cmd_ready", int'(cmd_ready), 0);
            #4;
        end
        accept_response();
        check_eq("cmd_ready", int'(cmd_ready), 1);
        end_test(6, "back-pressure");

        check_eq("bound assertion failures", i_dut.i_chk.fail_cnt, 0);
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verif/i2c_slave_model.sv
module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  logic       scl,
    input  logic       sda,
    input  logic [7:0] nack_after,
    output logic       sda_oe
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] wr_mem [16];
    logic [7:0] wr_cnt;
    logic [7:0] rd_cnt;
    logic [7:0] shreg;
    logic [7:0] rd_sr;
    logic [3:0] bit_idx;
    logic       active;
    logic       addr_phase;
    logic       is_read;
    logic       sampled;
    logic       master_nack;
    logic       stop_seen;
    int         nack_cnt;
    int         nack_idx;

    initial begin
        sda_oe    = 1'b0;
        active    = 1'b0;
        stop_seen = 1'b0;
        wr_cnt    = 8'd0;
        rd_cnt    = 8'd0;
        nack_cnt  = 0;
        nack_idx  = -1;
    end

    // a START clears the log of the previous transfer.
    always @(negedge sda) begin
        if (scl) begin
            active      = 1'b1;
            addr_phase  = 1'b1;
            is_read     = 1'b0;
            sampled     = 1'b0;
            master_nack = 1'b0;
            bit_idx     = 4'd0;
            wr_cnt      = 8'd0;
            rd_cnt      = 8'd0;
            nack_cnt    = 0;
            nack_idx    = -1;
            stop_seen   = 1'b0;
            sda_oe      = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl) begin
            active    = 1'b0;
            sda_oe    = 1'b0;
            stop_seen = 1'b1;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bit_idx < 4'd8) begin
                shreg = {shreg[6:0], sda};
            end else if (is_read && !addr_phase && sda) begin
                master_nack = 1'b1;
                nack_cnt    = nack_cnt + 1;
                nack_idx    = int'(rd_cnt) - 1;
            end
            sampled = 1'b1;
        end
    end

    // SDA only moves right after SCL falls.
    always @(negedge scl) begin
        if (active && sampled) begin
            sampled = 1'b0;
            if (bit_idx < 4'd7) begin
                bit_idx = bit_idx + 4'd1;
                if (is_read && !addr_phase) begin
                    sda_oe = ~rd_sr[7];
                    rd_sr  = {rd_sr[6:0], 1'b0};
                end
            end else if (bit_idx == 4'd7) begin
                bit_idx = 4'd8;
                if (addr_phase) begin
                    is_read = shreg[0];
                    if (shreg[7:1] == DEV_ADDR) begin
                        sda_oe = 1'b1;
                    end else begin
                        active = 1'b0;
                        sda_oe = 1'b0;
                    end
                end else if (is_read) begin
                    sda_oe = 1'b0;
                end else begin
                    wr_mem[wr_cnt[3:0]] = shreg;
                    sda_oe = (wr_cnt != nack_after);
                    wr_cnt = wr_cnt + 8'd1;
                end
            end else begin
                bit_idx = 4'd0;
                if (is_read && !master_nack) begin
                    rd_sr  = rd_cnt ^ 8'hA5;
                    rd_cnt = rd_cnt + 8'd1;
                    sda_oe = ~rd_sr[7];
                    rd_sr  = {rd_sr[6:0], 1'b0};
                end else begin
                    sda_oe = 1'b0;
                end
                addr_phase = 1'b0;
            end
        end
    end

endmodule

// File: verif/i2c_master_assert.sv
module i2c_master_assert (
    input logic                      I2C_CLK,
    input logic                      RST,
    input logic                      sda_in,
    input logic                      scl_in,
    input logic                      cmd_ready,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input i2c_host_pkg::i2c_rsp_t    rsp,
    input i2c_proto_pkg::seq_state_e state
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // with SCL high, only a START or a STOP may move SDA.
    a_sda_stable: assert property (@(posedge I2C_CLK) disable iff (RST)
        (scl_in && $past(scl_in) && (sda_in != $past(sda_in)))
            |-> (state == i2c_proto_pkg::ST_START || state == i2c_proto_pkg::ST_STOP))
        else begin
            $error("SDA changed while SCL was high outside START and STOP");
            fail_cnt++;
        end

    // the command channel stays closed while a response waits and reopens once it is taken.
    a_ready_excl: assert property (@(posedge I2C_CLK) disable iff (RST)
        rsp_valid |=> ($past(rsp_ready) ? (cmd_ready && !rsp_valid) : !cmd_ready))
        else begin
            $error("cmd_ready wrong around a pending response");
            fail_cnt++;
        end

    a_rsp_hold: assert property (@(posedge I2C_CLK) disable iff (RST)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else begin
            $error("response dropped or changed under back-pressure");
            fail_cnt++;
        end

endmodule

bind i2c_master_top i2c_master_assert i_chk (
    .I2C_CLK   (I2C_CLK),
    .RST       (RST),
    .sda_in    (sda_in),
    .scl_in    (scl_in),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .state     (i_seq.state)
);

// File: logic/i2c_master_top.sv
module i2c_master_top #(
    parameter int BUF_BYTES = 16,
    localparam int AW = $clog2(BUF_BYTES)
) (
    input  logic                   I2C_CLK,
    input  logic                   RST,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  i2c_host_pkg::i2c_cmd_t cmd,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output i2c_host_pkg::i2c_rsp_t rsp,
    input  logic                   buf_wr_en,
    input  logic [AW-1:0]          buf_wr_addr,
    input  logic [7:0]             buf_wr_data,
    input  logic [AW-1:0]          buf_rd_addr,
    output logic [7:0]             buf_rd_data,
    input  logic                   sda_in,
    input  logic                   scl_in,
    output logic                   sda_oe,
    output logic                   scl_oe
);

    i2c_proto_pkg::bit_phase_e phase;
    i2c_proto_pkg::drv_mode_e  drive_mode;
    logic                      bit_last;
    logic                      ack_bit;
    logic [7:0]                rx_byte;
    logic                      load_byte;
    logic [7:0]                tx_byte;
    logic                      shift_en;
    logic [AW-1:0]             eng_addr;
    logic                      eng_wr_en;
    logic [7:0]                eng_wr_data;
    logic [7:0]                eng_rd_data;
    logic                      tmr_run;
    logic                      scl_hold;

    i2c_seq_ctrl #(
        .BUF_BYTES (BUF_BYTES)
    ) i_seq (
        .I2C_CLK     (I2C_CLK),
        .RST         (RST),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .phase       (phase),
        .bit_last    (bit_last),
        .ack_bit     (ack_bit),
        .rx_byte     (rx_byte),
        .load_byte   (load_byte),
        .tx_byte     (tx_byte),
        .shift_en    (shift_en),
        .drive_mode  (drive_mode),
        .eng_addr    (eng_addr),
        .eng_wr_en   (eng_wr_en),
        .eng_wr_data (eng_wr_data),
        .eng_rd_data (eng_rd_data),
        .tmr_run     (tmr_run),
        .scl_hold    (scl_hold)
    );

    i2c_bit_timer i_timer (
        .I2C_CLK  (I2C_CLK),
        .RST      (RST),
        .tmr_run  (tmr_run),
        .scl_hold (scl_hold),
        .phase    (phase),
        .scl_oe   (scl_oe)
    );

    i2c_shift_unit i_shift (
        .I2C_CLK    (I2C_CLK),
        .RST        (RST),
        .phase      (phase),
        .load_byte  (load_byte),
        .tx_byte    (tx_byte),
        .shift_en   (shift_en),
        .drive_mode (drive_mode),
        .sda_in     (sda_in),
        .sda_oe     (sda_oe),
        .bit_last   (bit_last),
        .ack_bit    (ack_bit),
        .rx_byte    (rx_byte)
    );

    i2c_byte_buf #(
        .BUF_BYTES (BUF_BYTES)
    ) i_buf (
        .I2C_CLK     (I2C_CLK),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .buf_rd_addr (buf_rd_addr),
        .buf_rd_data (buf_rd_data),
        .eng_addr    (eng_addr),
        .eng_wr_en   (eng_wr_en),
        .eng_wr_data (eng_wr_data),
        .eng_rd_data (eng_rd_data)
    );

endmodule

// File: logic/i2c_byte_buf.sv
module i2c_byte_buf #(
    parameter int BUF_BYTES = 16,
    localparam int AW = $clog2(BUF_BYTES)
) (
    input  logic          I2C_CLK,
    input  logic          buf_wr_en,
    input  logic [AW-1:0] buf_wr_addr,
    input  logic [7:0]    buf_wr_data,
    input  logic [AW-1:0] buf_rd_addr,
    output logic [7:0]    buf_rd_data,
    input  logic [AW-1:0] eng_addr,
    input  logic          eng_wr_en,
    input  logic [7:0]    eng_wr_data,
    output logic [7:0]    eng_rd_data
);

    logic [7:0] mem [BUF_BYTES];
    logic       host_blocked;

    // the engine wins a same-address write collision.
    assign host_blocked = eng_wr_en && (eng_addr == buf_wr_addr);

    always_ff @(posedge I2C_CLK) begin
        if (buf_wr_en && !host_blocked)
            mem[buf_wr_addr] <= buf_wr_data;
        if (eng_wr_en)
            mem[eng_addr] <= eng_wr_data;
    end

    // both read ports return data one cycle after the address.
    always_ff @(posedge I2C_CLK) begin
        buf_rd_data <= mem[buf_rd_addr];
        eng_rd_data <= mem[eng_addr];
    end

endmodule

// File: logic/i2c_shift_unit.sv
module i2c_shift_unit (
    input  logic                      I2C_CLK,
    input  logic                      RST,
    input  i2c_proto_pkg::bit_phase_e phase,
    input  logic                      load_byte,
    input  logic [7:0]                tx_byte,
    input  logic                      shift_en,
    input  i2c_proto_pkg::drv_mode_e  drive_mode,
    input  logic                      sda_in,
    output logic                      sda_oe,
    output logic                      bit_last,
    output logic                      ack_bit,
    output logic [7:0]                rx_byte
);

    logic [7:0] tx_sr;
    logic [2:0] bit_cnt;
    logic       bit_step;

    assign bit_step = shift_en && (phase == i2c_proto_pkg::PH_3);
    assign bit_last = (bit_cnt == 3'd7);

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            bit_cnt <= 3'd0;
            sda_oe  <= 1'b0;
        end else begin
            if (load_byte)
                bit_cnt <= 3'd0;
            else if (bit_step)
                bit_cnt <= bit_cnt + 3'd1;

            // a release takes effect at once; every other mode waits for PH_0.
            if (drive_mode == i2c_proto_pkg::DRV_RELEASE) begin
                sda_oe <= 1'b0;
            end else if (phase == i2c_proto_pkg::PH_0) begin
                case (drive_mode)
                    i2c_proto_pkg::DRV_TX:  sda_oe <= ~tx_sr[7];
                    i2c_proto_pkg::DRV_ACK,
                    i2c_proto_pkg::DRV_LOW: sda_oe <= 1'b1;
                    default:                sda_oe <= 1'b0;
                endcase
            end
        end
    end

    // MSB first.
    always_ff @(posedge I2C_CLK) begin
        if (load_byte)
            tx_sr <= tx_byte;
        else if (bit_step)
            tx_sr <= {tx_sr[6:0], 1'b0};
    end

    always_ff @(posedge I2C_CLK) begin
        if (phase == i2c_proto_pkg::PH_1) begin
            ack_bit <= sda_in;
            if (shift_en)
                rx_byte <= {rx_byte[6:0], sda_in};
        end
    end

endmodule

// File: logic/i2c_bit_timer.sv
module i2c_bit_timer (
    input  logic                      I2C_CLK,
    input  logic                      RST,
    input  logic                      tmr_run,
    input  logic                      scl_hold,
    output i2c_proto_pkg::bit_phase_e phase,
    output logic                      scl_oe
);

    logic [1:0] ph_cnt;

    assign phase = i2c_proto_pkg::bit_phase_e'(ph_cnt);

    // SCL is pulled low at the end of a clocked bit and let go again after
    // PH_1 of the following bit, so it is high through PH_2 and PH_3.
    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            ph_cnt <= 2'd0;
            scl_oe <= 1'b0;
        end else if (!tmr_run) begin
            ph_cnt <= 2'd0;
            scl_oe <= 1'b0;
        end else begin
            ph_cnt <= ph_cnt + 2'd1;
            if (phase == i2c_proto_pkg::PH_3)
                scl_oe <= scl_hold;
            else if (phase == i2c_proto_pkg::PH_1)
                scl_oe <= 1'b0;
        end
    end

endmodule

// File: logic/i2c_seq_ctrl.sv
module i2c_seq_ctrl #(
    parameter int BUF_BYTES = 16,
    localparam int AW = $clog2(BUF_BYTES)
) (
    input  logic                      I2C_CLK,
    input  logic                      RST,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  i2c_host_pkg::i2c_cmd_t    cmd,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output i2c_host_pkg::i2c_rsp_t    rsp,
    input  i2c_proto_pkg::bit_phase_e phase,
    input  logic                      bit_last,
    input  logic                      ack_bit,
    input  logic [7:0]                rx_byte,
    output logic                      load_byte,
    output logic [7:0]                tx_byte,
    output logic                      shift_en,
    output i2c_proto_pkg::drv_mode_e  drive_mode,
    output logic [AW-1:0]             eng_addr,
    output logic                      eng_wr_en,
    output logic [7:0]                eng_wr_data,
    input  logic [7:0]                eng_rd_data,
    output logic                      tmr_run,
    output logic                      scl_hold
);

    i2c_proto_pkg::seq_state_e state;
    i2c_proto_pkg::seq_state_e next_state;
    i2c_host_pkg::i2c_cmd_t    cmd_q;
    logic [7:0]                byte_cnt;
    logic [7:0]                buf_ptr;
    logic                      nack_q;
    logic                      bit_end;
    logic                      last_byte;

    assign bit_end   = (phase == i2c_proto_pkg::PH_3);
    assign last_byte = (byte_cnt == cmd_q.length - 8'd1);

    always_comb begin
        next_state = state;
        case (state)
            i2c_proto_pkg::ST_IDLE: begin
                if (cmd_valid)
                    next_state = i2c_proto_pkg::ST_START;
            end
            i2c_proto_pkg::ST_START: begin
                if (bit_end)
                    next_state = i2c_proto_pkg::ST_ADDR;
            end
            i2c_proto_pkg::ST_ADDR: begin
                if (bit_end && bit_last)
                    next_state = i2c_proto_pkg::ST_AACK;
            end
            i2c_proto_pkg::ST_AACK: begin
                if (bit_end) begin
                    if (ack_bit)
                        next_state = i2c_proto_pkg::ST_STOP;
                    else if (cmd_q.op == i2c_host_pkg::OP_READ)
                        next_state = i2c_proto_pkg::ST_DATA_R;
                    else
                        next_state = i2c_proto_pkg::ST_DATA_W;
                end
            end
            i2c_proto_pkg::ST_DATA_W: begin
                if (bit_end && bit_last)
                    next_state = i2c_proto_pkg::ST_DACK_W;
            end
            i2c_proto_pkg::ST_DACK_W: begin
                if (bit_end) begin
                    if (ack_bit || last_byte)
                        next_state = i2c_proto_pkg::ST_STOP;
                    else
                        next_state = i2c_proto_pkg::ST_DATA_W;
                end
            end
            i2c_proto_pkg::ST_DATA_R: begin
                if (bit_end && bit_last)
                    next_state = i2c_proto_pkg::ST_DACK_R;
            end
            i2c_proto_pkg::ST_DACK_R: begin
                if (bit_end)
                    next_state = last_byte ? i2c_proto_pkg::ST_STOP : i2c_proto_pkg::ST_DATA_R;
            end
            i2c_proto_pkg::ST_STOP: begin
                if (bit_end)
                    next_state = i2c_proto_pkg::ST_RESP;
            end
            i2c_proto_pkg::ST_RESP: begin
                if (rsp_ready)
                    next_state = i2c_proto_pkg::ST_IDLE;
            end
            default: next_state = i2c_proto_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            state    <= i2c_proto_pkg::ST_IDLE;
            byte_cnt <= '0;
            nack_q   <= 1'b0;
        end else begin
            state <= next_state;
            if (cmd_valid && cmd_ready) begin
                byte_cnt <= '0;
                nack_q   <= 1'b0;
            end
            if (bit_end) begin
                if ((state == i2c_proto_pkg::ST_AACK || state == i2c_proto_pkg::ST_DACK_W)
                        && ack_bit)
                    nack_q <= 1'b1;
                if ((state == i2c_proto_pkg::ST_DACK_W && !ack_bit)
                        || state == i2c_proto_pkg::ST_DACK_R)
                    byte_cnt <= byte_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (cmd_valid && cmd_ready)
            cmd_q <= cmd;
    end

    assign cmd_ready = (state == i2c_proto_pkg::ST_IDLE);
    assign rsp_valid = (state == i2c_proto_pkg::ST_RESP);
    assign rsp       = '{nack: nack_q, bytes_done: byte_cnt};

    assign tmr_run  = (state != i2c_proto_pkg::ST_IDLE) && (state != i2c_proto_pkg::ST_RESP);
    assign scl_hold = tmr_run && (state != i2c_proto_pkg::ST_STOP);
    assign shift_en = (state == i2c_proto_pkg::ST_ADDR) || (state == i2c_proto_pkg::ST_DATA_W)
                   || (state == i2c_proto_pkg::ST_DATA_R);

    // a new byte enters the shifter only on entry to an address or write data byte.
    assign load_byte = bit_end && (next_state != state)
                    && (next_state == i2c_proto_pkg::ST_ADDR
                        || next_state == i2c_proto_pkg::ST_DATA_W);
    assign tx_byte   = (state == i2c_proto_pkg::ST_START) ? {cmd_q.dev_addr, cmd_q.op}
                                                          : eng_rd_data;

    // during a write acknowledge the buffer already looks one byte ahead.
    assign buf_ptr     = byte_cnt + {7'd0, state == i2c_proto_pkg::ST_DACK_W};
    assign eng_addr    = buf_ptr[AW-1:0];
    assign eng_wr_en   = (state == i2c_proto_pkg::ST_DACK_R) && (phase == i2c_proto_pkg::PH_2);
    assign eng_wr_data = rx_byte;

    always_comb begin
        case (state)
            i2c_proto_pkg::ST_START:  drive_mode = i2c_proto_pkg::DRV_LOW;
            i2c_proto_pkg::ST_ADDR,
            i2c_proto_pkg::ST_DATA_W: drive_mode = i2c_proto_pkg::DRV_TX;
            i2c_proto_pkg::ST_AACK,
            i2c_proto_pkg::ST_DACK_W,
            i2c_proto_pkg::ST_DATA_R: drive_mode = i2c_proto_pkg::DRV_RX;
            // the last read byte gets a NACK so the slave lets go of SDA.
            i2c_proto_pkg::ST_DACK_R: drive_mode = last_byte ? i2c_proto_pkg::DRV_RX
                                                             : i2c_proto_pkg::DRV_ACK;
            // SDA is held low until SCL has risen, then let go for the STOP.
            i2c_proto_pkg::ST_STOP: begin
                if (phase == i2c_proto_pkg::PH_0 || phase == i2c_proto_pkg::PH_1)
                    drive_mode = i2c_proto_pkg::DRV_LOW;
                else
                    drive_mode = i2c_proto_pkg::DRV_RELEASE;
            end
            default: drive_mode = i2c_proto_pkg::DRV_RELEASE;
        endcase
    end

endmodule

// File: logic/i2c_proto_pkg.sv
package i2c_proto_pkg;

    // one state per bus bit type; data states cover all eight bits of a byte.
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_AACK,
        ST_DATA_W,
        ST_DACK_W,
        ST_DATA_R,
        ST_DACK_R,
        ST_STOP,
        ST_RESP
    } seq_state_e;

    typedef enum logic [1:0] {
        PH_0,
        PH_1,
        PH_2,
        PH_3
    } bit_phase_e;

    // how the shift unit treats SDA in the current bit.
    typedef enum logic [2:0] {
        DRV_RELEASE,
        DRV_TX,
        DRV_RX,
        DRV_ACK,
        DRV_LOW
    } drv_mode_e;

endpackage

// File: logic/i2c_host_pkg.sv
package i2c_host_pkg;

    // the opcode doubles as the R/W bit sent after the device address.
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } i2c_op_e;

    // one command starts one complete transfer, from START to STOP.
    // length counts data bytes and must lie between 1 and the buffer depth.
    typedef struct packed {
        i2c_op_e    op;
        logic [6:0] dev_addr;
        logic [7:0] length;
    } i2c_cmd_t;

    // nack is set by an address NACK or by a NACK on written data.
    // bytes_done counts data bytes acknowledged by the slave in a write,
    // or data bytes received from the slave in a read.
    typedef struct packed {
        logic       nack;
        logic [7:0] bytes_done;
    } i2c_rsp_t;

endpackage
